// File: vlog.f
+incdir+tests
logic/st_bus_pkg.sv
logic/addr_decode.sv
logic/irq_ctrl.sv
logic/bus_ack.sv
logic/bus_slot_mux.sv
logic/st_glue_top.sv
tests/tb_st_glue.sv

// File: tests/tb_st_glue_checks.svh
// included inside the tb_st_glue module body, relies on its abort_run task
`ifndef TB_ST_GLUE_CHECKS_SVH
`define TB_ST_GLUE_CHECKS_SVH

// next state of the 32 bit linear congruential generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// reference word select, index 0 is the lowest 16 bits of the line
function automatic logic [15:0] word_of(input logic [63:0] line, input logic [1:0] index);
	case (index)
		2'd0: return line[15:0];
		2'd1: return line[31:16];
		2'd2: return line[47:32];
		default: return line[63:48];
	endcase
endfunction

task automatic check_periph(input string name, input st_bus_pkg::periph_t got,
	input st_bus_pkg::periph_t exp);
	if (got !== exp)
		abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_ipl(input string name, input st_bus_pkg::ipl_t got,
	input st_bus_pkg::ipl_t exp);
	if (got !== exp)
		abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_slot(input string name, input st_bus_pkg::slot_t got,
	input st_bus_pkg::slot_t exp);
	if (got !== exp)
		abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
	if (got !== exp)
		abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

// ram and master addresses are word addresses
task automatic check_addr(input string name, input logic [22:0] got, input logic [22:0] exp);
	if (got !== exp)
		abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
		abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

`endif

// File: tests/tb_st_glue.sv
// inputs change on the falling clk_8 edge, outputs are sampled a quarter period later
`default_nettype none
`timescale 1ns/1ps

module tb_st_glue;

	localparam int clk_period = 20;
	localparam int settle = 5;
	localparam int n_rows = 22;

	logic clk_8;
	logic pll_locked;
	logic [22:0] cpu_addr;
	logic [2:0] cpu_fc;
	logic cpu_as;
	logic cpu_rw;
	logic cpu_uds;
	logic cpu_lds;
	logic [15:0] cpu_dout;
	logic cpu_clr_berr;
	logic cpu_dtack;
	logic cpu_berr;
	logic [15:0] cpu_din;
	st_bus_pkg::mem_size_t mem_cfg;
	logic turbo;
	logic ste;
	logic blitter_fitted;
	logic st_vs;
	logic st_hs;
	logic mfp_irq;
	st_bus_pkg::ipl_t ipl;
	logic [22:0] vid_addr;
	logic vid_read;
	logic dio_br;
	logic [22:0] dio_addr;
	logic dio_read;
	logic dio_write;
	logic [15:0] dio_dout;
	logic blt_br;
	logic [22:0] blt_addr;
	logic blt_read;
	logic blt_write;
	logic [15:0] blt_dout;
	logic [63:0] ram_line;
	logic [15:0] io_rdata;
	logic [22:0] ram_addr;
	logic ram_oe;
	logic ram_wr;
	logic ram_uds;
	logic ram_lds;
	logic [15:0] ram_din;
	st_bus_pkg::slot_t slot;
	st_bus_pkg::periph_t periph;

	logic [31:0] rng;
	logic [39:0] rows [n_rows];

	st_glue_top dut (.*);

	always #(clk_period / 2) clk_8 = !clk_8;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	`include "tb_st_glue_checks.svh"

	// byte address, fc, rw, mem_cfg code, {turbo, ste}, periph, {dtack, oe, wr}
	// mem_cfg codes 0..5 are 512k, 1M, 2M, 4M, 8M, 14M
	initial begin
		rows[0] = {24'h000100, 3'd5, 1'b1, 3'd0, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b110};
		rows[1] = {24'h001000, 3'd5, 1'b0, 3'd3, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b101};
		// reset vector fetch from low rom
		rows[2] = {24'h000004, 3'd6, 1'b1, 3'd0, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b110};
		rows[3] = {24'h600000, 3'd5, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b000};
		rows[4] = {24'h600000, 3'd5, 1'b1, 3'd4, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b110};
		rows[5] = {24'h600000, 3'd5, 1'b1, 3'd5, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b110};
		rows[6] = {24'ha00000, 3'd5, 1'b1, 3'd4, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b000};
		rows[7] = {24'ha00000, 3'd5, 1'b1, 3'd5, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b110};
		rows[8] = {24'he00000, 3'd6, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b110};
		// rom write is never acknowledged
		rows[9] = {24'he00000, 3'd5, 1'b0, 3'd3, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b000};
		rows[10] = {24'hfc0000, 3'd6, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b110};
		rows[11] = {24'hfa0000, 3'd5, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b110};
		rows[12] = {24'he80000, 3'd5, 1'b1, 3'd3, 2'b10, st_bus_pkg::PERIPH_NONE, 3'b110};
		rows[13] = {24'he80000, 3'd5, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b000};
		rows[14] = {24'hff8200, 3'd5, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_VIDEO, 3'b100};
		rows[15] = {24'hff8800, 3'd5, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_PSG, 3'b100};
		rows[16] = {24'hff8a00, 3'd5, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b000};
		rows[17] = {24'hff8a00, 3'd5, 1'b1, 3'd3, 2'b01, st_bus_pkg::PERIPH_BLITTER, 3'b100};
		rows[18] = {24'hff8900, 3'd5, 1'b1, 3'd3, 2'b01, st_bus_pkg::PERIPH_STE_SND, 3'b100};
		rows[19] = {24'hfffa00, 3'd5, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_MFP, 3'b100};
		rows[20] = {24'hfffc00, 3'd5, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_ACIA, 3'b100};
		// iack at level 7, nothing pending
		rows[21] = {24'hfffffe, 3'd7, 1'b1, 3'd3, 2'b00, st_bus_pkg::PERIPH_NONE, 3'b100};
	end

	// returns on the falling edge inside the wanted slot
	task automatic wait_slot(input st_bus_pkg::slot_t s);
		@(negedge clk_8);
		while (slot !== s)
			@(negedge clk_8);
	endtask

	// ipl is polled on four falling edges after the change
	task automatic wait_ipl(input st_bus_pkg::ipl_t exp);
		int n;
		n = 0;
		@(negedge clk_8);
		while (ipl !== exp && n < 3) begin
			@(negedge clk_8);
			n++;
		end
		check_ipl("ipl", ipl, exp);
	endtask

	task automatic apply_map_table;
		logic [39:0] r;
		for (int i = 0; i < n_rows; i++) begin
			r = rows[i];
			wait_slot(st_bus_pkg::SLOT_CPU);
			cpu_addr = r[39:17];
			cpu_fc = r[15:13];
			cpu_rw = r[12];
			mem_cfg = st_bus_pkg::mem_size_t'(r[11:9]);
			turbo = r[8];
			ste = r[7];
			cpu_as = 1'b1;
			rng = lcg_next(rng);
			cpu_dout = rng[15:0];
			#settle;
			check_periph("periph", periph, st_bus_pkg::periph_t'(r[6:3]));
			check_bit("cpu_dtack", cpu_dtack, r[2]);
			check_bit("ram_oe", ram_oe, r[1]);
			check_bit("ram_wr", ram_wr, r[0]);
			// a cpu write puts the cpu data on the ram port
			if (r[0])
				check_word("ram_din", ram_din, cpu_dout);
		end
	endtask

	task automatic verify_slot_owners;
		// video fetch owns slot 0
		wait_slot(st_bus_pkg::SLOT_VIDEO);
		rng = lcg_next(rng);
		vid_addr = rng[22:0];
		vid_read = 1'b1;
		cpu_addr = 23'h000800;
		cpu_fc = 3'd5;
		cpu_rw = 1'b1;
		mem_cfg = st_bus_pkg::MEM_4M;
		turbo = 1'b0;
		ste = 1'b0;
		cpu_as = 1'b1;
		#settle;
		check_addr("ram_addr", ram_addr, vid_addr);
		check_bit("ram_oe", ram_oe, 1'b1);
		check_bit("ram_wr", ram_wr, 1'b0);
		// both masters request, data-io wins
		@(negedge clk_8);
		check_slot("slot", slot, st_bus_pkg::SLOT_CPU);
		rng = lcg_next(rng);
		dio_addr = rng[22:0];
		rng = lcg_next(rng);
		blt_addr = rng[22:0];
		rng = lcg_next(rng);
		dio_dout = rng[15:0];
		// cpu strobes idle, the master still drives both
		cpu_uds = 1'b1;
		cpu_lds = 1'b1;
		dio_br = 1'b1;
		dio_write = 1'b1;
		blt_br = 1'b1;
		blt_read = 1'b1;
		#settle;
		check_addr("ram_addr", ram_addr, dio_addr);
		check_word("ram_din", ram_din, dio_dout);
		check_bit("ram_uds", ram_uds, 1'b1);
		check_bit("ram_lds", ram_lds, 1'b1);
		check_bit("ram_wr", ram_wr, 1'b1);
		check_bit("ram_oe", ram_oe, 1'b0);
		check_bit("cpu_dtack", cpu_dtack, 1'b0);
		// blitter alone
		wait_slot(st_bus_pkg::SLOT_CPU);
		dio_br = 1'b0;
		dio_write = 1'b0;
		cpu_uds = 1'b0;
		cpu_lds = 1'b0;
		#settle;
		check_addr("ram_addr", ram_addr, blt_addr);
		check_bit("ram_oe", ram_oe, 1'b1);
		check_bit("cpu_dtack", cpu_dtack, 1'b0);
		// the blitter gets no port in the spare slot
		@(negedge clk_8);
		check_slot("slot", slot, st_bus_pkg::SLOT_SPARE);
		#settle;
		check_bit("ram_oe", ram_oe, 1'b0);
		// slot 3 idles without turbo
		@(negedge clk_8);
		check_slot("slot", slot, st_bus_pkg::SLOT_TURBO);
		blt_br = 1'b0;
		blt_read = 1'b0;
		#settle;
		check_bit("ram_oe", ram_oe, 1'b0);
		check_bit("ram_wr", ram_wr, 1'b0);
		check_bit("cpu_dtack", cpu_dtack, 1'b0);
		wait_slot(st_bus_pkg::SLOT_TURBO);
		turbo = 1'b1;
		#settle;
		check_addr("ram_addr", ram_addr, cpu_addr);
		check_bit("ram_oe", ram_oe, 1'b1);
		check_bit("cpu_dtack", cpu_dtack, 1'b1);
	endtask

	task automatic sample_read_words;
		for (int k = 0; k < 8; k++) begin
			wait_slot(st_bus_pkg::SLOT_CPU);
			rng = lcg_next(rng);
			ram_line[31:0] = rng;
			rng = lcg_next(rng);
			ram_line[63:32] = rng;
			rng = lcg_next(rng);
			// anywhere in the first 4 MB
			cpu_addr = {2'b00, rng[20:0]};
			turbo = 1'b0;
			cpu_as = 1'b1;
			#settle;
			check_word("cpu_din", cpu_din, word_of(ram_line, cpu_addr[1:0]));
		end
		// blitter window on a plain ST selects nothing
		wait_slot(st_bus_pkg::SLOT_CPU);
		rng = lcg_next(rng);
		io_rdata = rng[15:0];
		cpu_addr = 23'h7fc500;
		#settle;
		check_periph("periph", periph, st_bus_pkg::PERIPH_NONE);
		check_word("cpu_din", cpu_din, io_rdata);
	endtask

	// acknowledge one autovectored level and expect the request gone
	task automatic ack_level(input logic [22:0] addr, input logic [15:0] vector);
		wait_slot(st_bus_pkg::SLOT_CPU);
		cpu_addr = addr;
		cpu_fc = 3'd7;
		cpu_rw = 1'b1;
		cpu_as = 1'b1;
		#settle;
		check_word("cpu_din", cpu_din, vector);
		check_bit("cpu_dtack", cpu_dtack, 1'b1);
		@(negedge clk_8);
		cpu_as = 1'b0;
		cpu_fc = 3'd5;
		wait_ipl(st_bus_pkg::IPL_NONE);
	endtask

	task automatic service_interrupts;
		wait_slot(st_bus_pkg::SLOT_VIDEO);
		cpu_as = 1'b0;
		check_ipl("ipl", ipl, st_bus_pkg::IPL_NONE);
		st_vs = 1'b1;
		wait_ipl(st_bus_pkg::IPL_VBI);
		st_vs = 1'b0;
		mfp_irq = 1'b1;
		wait_ipl(st_bus_pkg::IPL_MFP);
		// vbi is still pending underneath
		mfp_irq = 1'b0;
		wait_ipl(st_bus_pkg::IPL_VBI);
		ack_level(23'h7ffffc, 16'h001c);
		st_hs = 1'b1;
		wait_ipl(st_bus_pkg::IPL_HBI);
		st_hs = 1'b0;
		ack_level(23'h7ffffa, 16'h001a);
	endtask

	task automatic run_into_bus_error;
		wait_slot(st_bus_pkg::SLOT_SPARE);
		cpu_as = 1'b0;
		cpu_clr_berr = 1'b1;
		turbo = 1'b0;
		// unmapped read at $600000 with 4 MB fitted
		@(negedge clk_8);
		cpu_clr_berr = 1'b0;
		cpu_addr = 23'h300000;
		mem_cfg = st_bus_pkg::MEM_4M;
		cpu_fc = 3'd5;
		cpu_rw = 1'b1;
		cpu_as = 1'b1;
		for (int k = 0; k < st_bus_pkg::berr_limit; k++) begin
			wait_slot(st_bus_pkg::SLOT_CPU);
			#settle;
			check_bit("cpu_berr", cpu_berr, 1'b0);
			check_bit("cpu_dtack", cpu_dtack, 1'b0);
		end
		wait_slot(st_bus_pkg::SLOT_CPU);
		#settle;
		check_bit("cpu_berr", cpu_berr, 1'b1);
		@(negedge clk_8);
		cpu_clr_berr = 1'b1;
		cpu_as = 1'b0;
		@(negedge clk_8);
		cpu_clr_berr = 1'b0;
		check_bit("cpu_berr", cpu_berr, 1'b0);
	endtask

	initial begin
		clk_8 = 1'b0;
		pll_locked = 1'b0;
		rng = 32'd5351;
		cpu_addr = '0;
		cpu_fc = 3'd5;
		cpu_as = 1'b0;
		cpu_rw = 1'b1;
		// both data strobes active
		cpu_uds = 1'b0;
		cpu_lds = 1'b0;
		cpu_dout = '0;
		cpu_clr_berr = 1'b0;
		mem_cfg = st_bus_pkg::MEM_4M;
		turbo = 1'b0;
		ste = 1'b0;
		blitter_fitted = 1'b0;
		st_vs = 1'b0;
		st_hs = 1'b0;
		mfp_irq = 1'b0;
		vid_addr = '0;
		vid_read = 1'b0;
		dio_br = 1'b0;
		dio_addr = '0;
		dio_read = 1'b0;
		dio_write = 1'b0;
		dio_dout = '0;
		blt_br = 1'b0;
		blt_addr = '0;
		blt_read = 1'b0;
		blt_write = 1'b0;
		blt_dout = '0;
		ram_line = '0;
		io_rdata = '0;
		repeat (16) @(posedge clk_8);
		@(negedge clk_8);
		pll_locked = 1'b1;
		apply_map_table;
		verify_slot_owners;
		sample_read_words;
		service_interrupts;
		run_into_bus_error;
		$display("Testbench passed");
		$finish;
	end

	// watchdog, generous against the table length
	initial begin
		#((n_rows * 8 + 400) * clk_period);
		abort_run("timeout, the tests did not finish in time");
	end

endmodule

`default_nettype wire

// File: logic/st_glue_top.sv
// glue only, no registers added on any path; peripherals and the ram controller sit outside
`default_nettype none
`timescale 1ns/1ps

module st_glue_top (
	input wire clk_8,
	input wire pll_locked,
	// cpu bus
	input wire [st_bus_pkg::addr_w-1:0] cpu_addr,
	input wire [2:0] cpu_fc,
	input wire cpu_as,
	input wire cpu_rw,
	input wire cpu_uds,
	input wire cpu_lds,
	input wire [st_bus_pkg::data_w-1:0] cpu_dout,
	input wire cpu_clr_berr,
	output logic cpu_dtack,
	output logic cpu_berr,
	output logic [st_bus_pkg::data_w-1:0] cpu_din,
	// system configuration
	input wire st_bus_pkg::mem_size_t mem_cfg,
	input wire turbo,
	input wire ste,
	input wire blitter_fitted,
	// interrupt sources
	input wire st_vs,
	input wire st_hs,
	input wire mfp_irq,
	output st_bus_pkg::ipl_t ipl,
	// other bus masters
	input wire [st_bus_pkg::addr_w-1:0] vid_addr,
	input wire vid_read,
	input wire dio_br,
	input wire [st_bus_pkg::addr_w-1:0] dio_addr,
	input wire dio_read,
	input wire dio_write,
	input wire [st_bus_pkg::data_w-1:0] dio_dout,
	input wire blt_br,
	input wire [st_bus_pkg::addr_w-1:0] blt_addr,
	input wire blt_read,
	input wire blt_write,
	input wire [st_bus_pkg::data_w-1:0] blt_dout,
	// ram port and the peripheral read data
	input wire [st_bus_pkg::line_w-1:0] ram_line,
	input wire [st_bus_pkg::data_w-1:0] io_rdata,
	output logic [st_bus_pkg::addr_w-1:0] ram_addr,
	output logic ram_oe,
	output logic ram_wr,
	output logic ram_uds,
	output logic ram_lds,
	output logic [st_bus_pkg::data_w-1:0] ram_din,
	output st_bus_pkg::slot_t slot,
	output st_bus_pkg::periph_t periph
);

	wire st_bus_pkg::region_t region;
	wire cpu_slot;
	wire bus_req;
	wire [7:0] auto_vector;

	// address classification
	addr_decode u_addr_decode (
		.cpu_addr(cpu_addr), .cpu_fc(cpu_fc), .cpu_rw(cpu_rw), .mem_cfg(mem_cfg),
		.turbo(turbo), .ste(ste), .blitter_fitted(blitter_fitted),
		.region(region), .periph(periph)
	);

	irq_ctrl u_irq_ctrl (
		.clk_8(clk_8), .pll_locked(pll_locked), .st_vs(st_vs), .st_hs(st_hs),
		.mfp_irq(mfp_irq), .region(region), .cpu_as(cpu_as), .cpu_addr(cpu_addr),
		.ipl(ipl), .auto_vector(auto_vector)
	);

	// cycle termination
	bus_ack u_bus_ack (
		.clk_8(clk_8), .pll_locked(pll_locked), .cpu_slot(cpu_slot), .bus_req(bus_req),
		.region(region), .periph(periph), .cpu_as(cpu_as), .cpu_clr_berr(cpu_clr_berr),
		.cpu_dtack(cpu_dtack), .cpu_berr(cpu_berr)
	);

	// slots, ram arbitration and cpu read data
	bus_slot_mux u_bus_slot_mux (
		.clk_8(clk_8), .pll_locked(pll_locked), .turbo(turbo), .region(region),
		.cpu_addr(cpu_addr), .cpu_as(cpu_as), .cpu_rw(cpu_rw), .cpu_uds(cpu_uds),
		.cpu_lds(cpu_lds), .cpu_dout(cpu_dout), .vid_addr(vid_addr), .vid_read(vid_read),
		.dio_br(dio_br), .dio_addr(dio_addr), .dio_read(dio_read), .dio_write(dio_write),
		.dio_dout(dio_dout), .blt_br(blt_br), .blt_addr(blt_addr), .blt_read(blt_read),
		.blt_write(blt_write), .blt_dout(blt_dout), .ram_line(ram_line),
		.io_rdata(io_rdata), .auto_vector(auto_vector), .slot(slot), .cpu_slot(cpu_slot),
		.bus_req(bus_req), .ram_addr(ram_addr), .ram_oe(ram_oe), .ram_wr(ram_wr),
		.ram_uds(ram_uds), .ram_lds(ram_lds), .ram_din(ram_din), .cpu_din(cpu_din)
	);

endmodule

`default_nettype wire

// File: logic/bus_slot_mux.sv
// four slot bus, turbo adds slot 3 for the cpu; cpu_uds/cpu_lds are active low, ram strobes high
`default_nettype none
`timescale 1ns/1ps

module bus_slot_mux (
	input wire clk_8,
	input wire pll_locked,
	input wire turbo,
	input wire st_bus_pkg::region_t region,
	input wire [st_bus_pkg::addr_w-1:0] cpu_addr,
	input wire cpu_as,
	input wire cpu_rw,
	input wire cpu_uds,
	input wire cpu_lds,
	input wire [st_bus_pkg::data_w-1:0] cpu_dout,
	input wire [st_bus_pkg::addr_w-1:0] vid_addr,
	input wire vid_read,
	input wire dio_br,
	input wire [st_bus_pkg::addr_w-1:0] dio_addr,
	input wire dio_read,
	input wire dio_write,
	input wire [st_bus_pkg::data_w-1:0] dio_dout,
	input wire blt_br,
	input wire [st_bus_pkg::addr_w-1:0] blt_addr,
	input wire blt_read,
	input wire blt_write,
	input wire [st_bus_pkg::data_w-1:0] blt_dout,
	input wire [st_bus_pkg::line_w-1:0] ram_line,
	input wire [st_bus_pkg::data_w-1:0] io_rdata,
	input wire [7:0] auto_vector,
	output st_bus_pkg::slot_t slot,
	output logic cpu_slot,
	output logic bus_req,
	output logic [st_bus_pkg::addr_w-1:0] ram_addr,
	output logic ram_oe,
	output logic ram_wr,
	output logic ram_uds,
	output logic ram_lds,
	output logic [st_bus_pkg::data_w-1:0] ram_din,
	output logic [st_bus_pkg::data_w-1:0] cpu_din
);

	logic video_slot;
	logic cpu_mem;
	logic cpu_oe;
	logic cpu_wr;

	// slot counter, free running from the video slot
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			slot <= st_bus_pkg::SLOT_VIDEO;
		end else begin
			slot <= st_bus_pkg::slot_t'(slot + 2'd1);
		end
	end

	assign video_slot = (slot == st_bus_pkg::SLOT_VIDEO);
	// the turbo slot only belongs to the cpu when turbo is on
	assign cpu_slot = (slot == st_bus_pkg::SLOT_CPU) ||
		(turbo && (slot == st_bus_pkg::SLOT_TURBO));

	// dma and blitter only ever halt the cpu
	assign bus_req = dio_br || blt_br;

	// cpu reads ram and rom, writes ram only
	assign cpu_mem = (region == st_bus_pkg::REGION_RAM) || (region == st_bus_pkg::REGION_ROM);
	assign cpu_oe = cpu_as && cpu_rw && cpu_mem;
	assign cpu_wr = cpu_as && !cpu_rw && (region == st_bus_pkg::REGION_RAM);

	always_comb begin
		// default is the cpu side, idle in the spare slot
		ram_addr = cpu_addr;
		ram_oe = 1'b0;
		ram_wr = 1'b0;
		ram_uds = !cpu_uds;
		ram_lds = !cpu_lds;
		ram_din = cpu_dout;
		if (video_slot) begin
			// video fetch is read only, full words
			ram_addr = vid_addr;
			ram_oe = vid_read;
			ram_uds = 1'b1;
			ram_lds = 1'b1;
		end else if (dio_br) begin
			// data-io wins over everything in any cpu slot
			ram_addr = dio_addr;
			ram_oe = cpu_slot && dio_read;
			ram_wr = cpu_slot && dio_write;
			ram_uds = 1'b1;
			ram_lds = 1'b1;
			ram_din = dio_dout;
		end else if (blt_br) begin
			ram_addr = blt_addr;
			ram_oe = cpu_slot && blt_read;
			ram_wr = cpu_slot && blt_write;
			ram_uds = 1'b1;
			ram_lds = 1'b1;
			ram_din = blt_dout;
		end else begin
			ram_oe = cpu_slot && cpu_oe;
			ram_wr = cpu_slot && cpu_wr;
		end
	end

	always_comb begin
		if (region == st_bus_pkg::REGION_IACK) begin
			// vector byte on d7..d0
			cpu_din = {8'h00, auto_vector};
		end else if (cpu_mem) begin
			// word out of the 64 bit line, picked by A2..A1
			cpu_din = ram_line[{cpu_addr[1:0], 4'b0000} +: st_bus_pkg::data_w];
		end else begin
			cpu_din = io_rdata;
		end
	end

	// a master never reads and writes the ram in the same slot
	a_oe_wr_excl: assert property (@(posedge clk_8) disable iff (!pll_locked)
		!(ram_oe && ram_wr));

endmodule

`default_nettype wire

// File: logic/bus_ack.sv
// dtack is combinational; a timed out cycle stays in bus error until the cpu clears it
`default_nettype none
`timescale 1ns/1ps

module bus_ack (
	input wire clk_8,
	input wire pll_locked,
	input wire cpu_slot,
	input wire bus_req,
	input wire st_bus_pkg::region_t region,
	input wire st_bus_pkg::periph_t periph,
	input wire cpu_as,
	input wire cpu_clr_berr,
	output logic cpu_dtack,
	output logic cpu_berr
);

	localparam int cnt_w = $clog2(st_bus_pkg::berr_limit + 1);

	logic mapped;
	logic [cnt_w-1:0] timeout;

	// memory, iack and any present peripheral answer
	assign mapped = (region == st_bus_pkg::REGION_RAM) ||
		(region == st_bus_pkg::REGION_ROM) ||
		(region == st_bus_pkg::REGION_IACK) ||
		((region == st_bus_pkg::REGION_IO) && (periph != st_bus_pkg::PERIPH_NONE));

	// another master holds the cpu off by withholding dtack
	assign cpu_dtack = cpu_as && cpu_slot && !bus_req && mapped;

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			timeout <= '0;
		end else if (cpu_clr_berr) begin
			timeout <= '0;
		end else if (cpu_slot && cpu_as) begin
			// an acknowledged or stolen cycle restarts the count
			if (cpu_dtack || bus_req)
				timeout <= '0;
			else if (timeout != cnt_w'(st_bus_pkg::berr_limit))
				timeout <= timeout + 1'b1;
		end
	end

	assign cpu_berr = (timeout == cnt_w'(st_bus_pkg::berr_limit));

	// a bus error only follows a cpu slot that went unanswered
	a_berr_cause: assert property (@(posedge clk_8) disable iff (!pll_locked)
		$rose(cpu_berr) |-> $past(cpu_slot && cpu_as && !cpu_dtack && !bus_req));

endmodule

`default_nettype wire

// File: logic/irq_ctrl.sv
// sync inputs need no extra synchroniser; only levels 4 and 2 are autovectored here, mfp has its own
`default_nettype none
`timescale 1ns/1ps

module irq_ctrl (
	input wire clk_8,
	input wire pll_locked,
	input wire st_vs,
	input wire st_hs,
	input wire mfp_irq,
	input wire st_bus_pkg::region_t region,
	input wire cpu_as,
	input wire [st_bus_pkg::addr_w-1:0] cpu_addr,
	output st_bus_pkg::ipl_t ipl,
	output logic [7:0] auto_vector
);

	logic vs_d1;
	logic vs_d2;
	logic hs_d1;
	logic hs_d2;
	logic vbi;
	logic hbi;
	logic iack_cycle;
	logic vbi_ack;
	logic hbi_ack;

	// acknowledged level sits on A3..A1
	assign iack_cycle = cpu_as && (region == st_bus_pkg::REGION_IACK);
	assign vbi_ack = iack_cycle && (cpu_addr[2:0] == st_bus_pkg::lvl_vbi);
	assign hbi_ack = iack_cycle && (cpu_addr[2:0] == st_bus_pkg::lvl_hbi);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			vs_d1 <= 1'b0;
			vs_d2 <= 1'b0;
			hs_d1 <= 1'b0;
			hs_d2 <= 1'b0;
			vbi <= 1'b0;
			hbi <= 1'b0;
		end else begin
			vs_d1 <= st_vs;
			vs_d2 <= vs_d1;
			hs_d1 <= st_hs;
			hs_d2 <= hs_d1;
			// acknowledge beats a new edge in the same cycle
			if (vbi_ack)
				vbi <= 1'b0;
			else if (vs_d1 && !vs_d2)
				vbi <= 1'b1;
			if (hbi_ack)
				hbi <= 1'b0;
			else if (hs_d1 && !hs_d2)
				hbi <= 1'b1;
		end
	end

	// mfp at level 6 over vbi at 4 over hbi at 2
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			ipl <= st_bus_pkg::IPL_NONE;
		end else if (mfp_irq) begin
			ipl <= st_bus_pkg::IPL_MFP;
		end else if (vbi) begin
			ipl <= st_bus_pkg::IPL_VBI;
		end else if (hbi) begin
			ipl <= st_bus_pkg::IPL_HBI;
		end else begin
			ipl <= st_bus_pkg::IPL_NONE;
		end
	end

	// vector byte in the same cycle as the acknowledge
	always_comb begin
		auto_vector = 8'h00;
		if (vbi_ack)
			auto_vector = st_bus_pkg::vec_vbi;
		else if (hbi_ack)
			auto_vector = st_bus_pkg::vec_hbi;
	end

endmodule

`default_nettype wire

// File: logic/addr_decode.sv
// purely combinational map; rom is read only, peripheral selects exist only in the $ff I/O page
`default_nettype none
`timescale 1ns/1ps

module addr_decode (
	input wire [st_bus_pkg::addr_w-1:0] cpu_addr,
	input wire [2:0] cpu_fc,
	input wire cpu_rw,
	input wire st_bus_pkg::mem_size_t mem_cfg,
	input wire turbo,
	input wire ste,
	input wire blitter_fitted,
	output st_bus_pkg::region_t region,
	output st_bus_pkg::periph_t periph
);

	logic iack;
	logic low_rom;
	logic ram_hit;
	logic rom_hit;
	logic io_hit;
	logic [15:0] io_off;
	st_bus_pkg::periph_t io_periph;

	// true when the offset lies in the window at base with low don't-care bits
	function automatic logic in_window(input logic [15:0] off, input logic [15:0] base,
		input int low);
		return (off >> low) == (base >> low);
	endfunction

	assign iack = (cpu_fc == st_bus_pkg::fc_iack);

	// reset vectors come from rom at $000000..$000007
	assign low_rom = (cpu_addr[22:2] == 21'd0);

	// 4 MB always, 8 MB and 14 MB by config, 512k at $e80000 in turbo mode
	assign ram_hit = (cpu_addr[22:21] == 2'b00) ||
		((cpu_addr[22:21] == 2'b01) &&
			((mem_cfg == st_bus_pkg::MEM_8M) || (mem_cfg == st_bus_pkg::MEM_14M))) ||
		(((cpu_addr[22:21] == 2'b10) || (cpu_addr[22:20] == 3'b110)) &&
			(mem_cfg == st_bus_pkg::MEM_14M)) ||
		(turbo && (cpu_addr[22:18] == st_bus_pkg::turbo_ram_base));

	// tos 256k, tos 192k and the cartridge port
	assign rom_hit = (cpu_addr[22:17] == st_bus_pkg::tos256_base) ||
		(cpu_addr[22:16] == st_bus_pkg::tos192_base) ||
		(cpu_addr[22:15] == st_bus_pkg::tos192_tail) ||
		(cpu_addr[22:16] == st_bus_pkg::cart_base);

	assign io_hit = (cpu_addr[22:15] == st_bus_pkg::io_page);

	always_comb begin
		if (iack) begin
			region = st_bus_pkg::REGION_IACK;
		end else if (low_rom || (!ram_hit && rom_hit)) begin
			// rom writes stay unmapped and time out
			region = cpu_rw ? st_bus_pkg::REGION_ROM : st_bus_pkg::REGION_NONE;
		end else if (ram_hit) begin
			region = st_bus_pkg::REGION_RAM;
		end else if (io_hit) begin
			region = st_bus_pkg::REGION_IO;
		end else begin
			region = st_bus_pkg::REGION_NONE;
		end
	end

	// byte offset inside the I/O page
	assign io_off = {cpu_addr[14:0], 1'b0};

	always_comb begin
		io_periph = st_bus_pkg::PERIPH_NONE;
		if (in_window(io_off, st_bus_pkg::mmu_base, st_bus_pkg::mmu_low))
			io_periph = st_bus_pkg::PERIPH_MMU;
		else if (in_window(io_off, st_bus_pkg::video_base, st_bus_pkg::video_low))
			io_periph = st_bus_pkg::PERIPH_VIDEO;
		else if (in_window(io_off, st_bus_pkg::dma_base, st_bus_pkg::dma_low))
			io_periph = st_bus_pkg::PERIPH_DMA;
		else if (in_window(io_off, st_bus_pkg::psg_base, st_bus_pkg::psg_low))
			io_periph = st_bus_pkg::PERIPH_PSG;
		// the ste always has a blitter
		else if ((blitter_fitted || ste) &&
			in_window(io_off, st_bus_pkg::blitter_base, st_bus_pkg::blitter_low))
			io_periph = st_bus_pkg::PERIPH_BLITTER;
		else if (ste && in_window(io_off, st_bus_pkg::ste_snd_base, st_bus_pkg::ste_snd_low))
			io_periph = st_bus_pkg::PERIPH_STE_SND;
		else if (ste && in_window(io_off, st_bus_pkg::ste_joy_base, st_bus_pkg::ste_joy_low))
			io_periph = st_bus_pkg::PERIPH_STE_JOY;
		else if (in_window(io_off, st_bus_pkg::mfp_base, st_bus_pkg::mfp_low))
			io_periph = st_bus_pkg::PERIPH_MFP;
		else if (in_window(io_off, st_bus_pkg::acia_base, st_bus_pkg::acia_low))
			io_periph = st_bus_pkg::PERIPH_ACIA;
	end

	// an iack cycle on page $ff selects nothing
	assign periph = (region == st_bus_pkg::REGION_IO) ? io_periph : st_bus_pkg::PERIPH_NONE;

endmodule

`default_nettype wire

// File: logic/st_bus_pkg.sv
// shared types and map constants; word addresses drop bit 0, I/O offsets are byte offsets in page $ff
`default_nettype none

package st_bus_pkg;

	// bus widths
	localparam int addr_w = 23;
	localparam int data_w = 16;
	localparam int line_w = 64;

	// cpu cycles in a cpu slot without dtack before a bus error
	localparam int berr_limit = 15;

	// autovector bytes returned for the ST autovectored levels
	localparam logic [7:0] vec_vbi = 8'h1c;
	localparam logic [7:0] vec_hbi = 8'h1a;

	// function code of an interrupt acknowledge, and the acknowledged levels on A3..A1
	localparam logic [2:0] fc_iack = 3'b111;
	localparam logic [2:0] lvl_vbi = 3'b100;
	localparam logic [2:0] lvl_hbi = 3'b010;

	// upper address bits of the rom, cartridge, turbo ram and I/O areas
	localparam logic [5:0] tos256_base = 6'b111000;
	localparam logic [6:0] tos192_base = 7'b1111110;
	localparam logic [7:0] tos192_tail = 8'hfe;
	localparam logic [6:0] cart_base = 7'b1111101;
	localparam logic [4:0] turbo_ram_base = 5'b11101;
	localparam logic [7:0] io_page = 8'hff;

	// peripheral windows in the I/O page, base and number of don't-care low bits
	localparam logic [15:0] mmu_base = 16'h8000;
	localparam int mmu_low = 1;
	localparam logic [15:0] video_base = 16'h8200;
	localparam int video_low = 7;
	localparam logic [15:0] dma_base = 16'h8600;
	localparam int dma_low = 4;
	localparam logic [15:0] psg_base = 16'h8800;
	localparam int psg_low = 8;
	localparam logic [15:0] ste_snd_base = 16'h8900;
	localparam int ste_snd_low = 6;
	localparam logic [15:0] blitter_base = 16'h8a00;
	localparam int blitter_low = 8;
	localparam logic [15:0] ste_joy_base = 16'h9200;
	localparam int ste_joy_low = 6;
	localparam logic [15:0] mfp_base = 16'hfa00;
	localparam int mfp_low = 6;
	localparam logic [15:0] acia_base = 16'hfc00;
	localparam int acia_low = 8;

	typedef enum logic [2:0] {
		MEM_512K, MEM_1M, MEM_2M, MEM_4M, MEM_8M, MEM_14M
	} mem_size_t;

	typedef enum logic [2:0] {
		REGION_NONE, REGION_RAM, REGION_ROM, REGION_IO, REGION_IACK
	} region_t;

	typedef enum logic [3:0] {
		PERIPH_NONE, PERIPH_MMU, PERIPH_VIDEO, PERIPH_DMA, PERIPH_PSG,
		PERIPH_BLITTER, PERIPH_STE_SND, PERIPH_MFP, PERIPH_ACIA, PERIPH_STE_JOY
	} periph_t;

	typedef enum logic [1:0] {
		SLOT_VIDEO, SLOT_CPU, SLOT_SPARE, SLOT_TURBO
	} slot_t;

	// active low level as seen on the 68000 ipl pins, ipl0 always high
	typedef enum logic [2:0] {
		IPL_MFP = 3'd1, IPL_VBI = 3'd3, IPL_HBI = 3'd5, IPL_NONE = 3'd7
	} ipl_t;

endpackage

`default_nettype wire
